//--- hw/fsync_pkg.sv
package fsync_pkg;

  // the grid is N_ROWS x N_COLS compute units, indexed row-major.
  localparam int unsigned N_ROWS = 4;
  localparam int unsigned N_COLS = 4;
  localparam int unsigned N_CUS = N_ROWS * N_COLS;

  // number of H-tree levels above the compute units.
  localparam int unsigned N_LEVELS = 4;

  // number of barrier ids that can be pending at once in every node.
  localparam int unsigned N_IDS = 4;

  localparam int unsigned LVL_W = 3;
  localparam int unsigned ID_W = $clog2(N_IDS);

  // target level of a barrier; only 1 to N_LEVELS are legal.
  typedef logic [LVL_W-1:0] fsync_lvl_t;

  typedef logic [ID_W-1:0] fsync_id_t;

  // kind of message a node sends down to one of its children.
  typedef enum logic [1:0] {
    MSG_NONE  = 2'd0,
    MSG_WAKE  = 2'd1,
    MSG_ERROR = 2'd2
  } fsync_msg_e;

endpackage : fsync_pkg

//--- hw/fsync_node_rf.sv
`timescale 1ns/1ps

module fsync_node_rf (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  set_a_i,
  input  logic                  set_b_i,
  input  fsync_pkg::fsync_id_t  set_id_a_i,
  input  fsync_pkg::fsync_id_t  set_id_b_i,
  input  fsync_pkg::fsync_lvl_t set_lvl_a_i,
  input  fsync_pkg::fsync_lvl_t set_lvl_b_i,
  input  logic                  take_i,
  input  fsync_pkg::fsync_id_t  take_id_i,
  output logic                  dup_a_o,
  output logic                  dup_b_o,
  output logic                  ready_o,
  output fsync_pkg::fsync_id_t  ready_id_o,
  output fsync_pkg::fsync_lvl_t ready_lvl_o
);

  import fsync_pkg::*;

  logic [N_IDS-1:0] pend_a_q, pend_b_q, rdy_q;
  logic [N_IDS-1:0] hit_a, hit_b, a_now, b_now, done, rdy_all, take_hit;
  fsync_lvl_t       pend_lvl_q [N_IDS];
  fsync_lvl_t       rdy_lvl_q [N_IDS];
  fsync_lvl_t       lvl_now [N_IDS];
  logic             eff_a, eff_b;

  // a set for an id already pending on the same child is flagged and dropped.
  assign dup_a_o = set_a_i & pend_a_q[set_id_a_i];
  assign dup_b_o = set_b_i & pend_b_q[set_id_b_i];
  assign eff_a   = set_a_i & ~dup_a_o;
  assign eff_b   = set_b_i & ~dup_b_o;

  always_comb begin
    for (int i = 0; i < N_IDS; i++) begin
      hit_a[i]    = eff_a && (set_id_a_i == fsync_id_t'(i));
      hit_b[i]    = eff_b && (set_id_b_i == fsync_id_t'(i));
      a_now[i]    = pend_a_q[i] | hit_a[i];
      b_now[i]    = pend_b_q[i] | hit_b[i];
      done[i]     = a_now[i] & b_now[i];
      rdy_all[i]  = rdy_q[i] | done[i];
      take_hit[i] = take_i && (take_id_i == fsync_id_t'(i));
      // the level of the first arrival is the one that counts.
      if (pend_a_q[i] || pend_b_q[i]) begin
        lvl_now[i] = pend_lvl_q[i];
      end else if (hit_a[i]) begin
        lvl_now[i] = set_lvl_a_i;
      end else begin
        lvl_now[i] = set_lvl_b_i;
      end
    end
  end

  // a pair completing in this cycle is presented right away, lowest id first.
  always_comb begin
    ready_o     = 1'b0;
    ready_id_o  = '0;
    ready_lvl_o = '0;
    for (int i = N_IDS - 1; i >= 0; i--) begin
      if (rdy_all[i]) begin
        ready_o     = 1'b1;
        ready_id_o  = fsync_id_t'(i);
        ready_lvl_o = rdy_q[i] ? rdy_lvl_q[i] : lvl_now[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_a_q <= '0;
      pend_b_q <= '0;
      rdy_q    <= '0;
    end else begin
      pend_a_q <= a_now & ~done;
      pend_b_q <= b_now & ~done;
      // when a held entry is taken, a fresh completion of the same id takes its place.
      rdy_q    <= (rdy_q & ~take_hit) | (done & ~(take_hit & ~rdy_q));
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N_IDS; i++) begin
      if (!pend_a_q[i] && !pend_b_q[i]) begin
        pend_lvl_q[i] <= lvl_now[i];
      end
      if (done[i] && (!rdy_q[i] || take_hit[i])) begin
        rdy_lvl_q[i] <= lvl_now[i];
      end
    end
  end

endmodule : fsync_node_rf

//--- hw/fsync_node.sv
`timescale 1ns/1ps

module fsync_node #(
  parameter int unsigned LEVEL = 1
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   ch_a_valid_i,
  input  fsync_pkg::fsync_lvl_t  ch_a_lvl_i,
  input  fsync_pkg::fsync_id_t   ch_a_id_i,
  input  logic                   ch_b_valid_i,
  input  fsync_pkg::fsync_lvl_t  ch_b_lvl_i,
  input  fsync_pkg::fsync_id_t   ch_b_id_i,
  input  fsync_pkg::fsync_msg_e  par_msg_i,
  input  fsync_pkg::fsync_lvl_t  par_lvl_i,
  input  fsync_pkg::fsync_id_t   par_id_i,
  output logic                   up_valid_o,
  output fsync_pkg::fsync_lvl_t  up_lvl_o,
  output fsync_pkg::fsync_id_t   up_id_o,
  output fsync_pkg::fsync_msg_e  ch_a_msg_o,
  output fsync_pkg::fsync_msg_e  ch_b_msg_o,
  output fsync_pkg::fsync_lvl_t  dn_lvl_o,
  output fsync_pkg::fsync_id_t   dn_id_o
);

  import fsync_pkg::*;

  // only the leaf level sees raw software requests and checks them.
  localparam bit CHECK = (LEVEL == 1);

  logic       bad_a, bad_b;
  logic       own_a, own_b, fwd_a, fwd_b;
  logic       own_dup_a, own_dup_b, fwd_dup_a, fwd_dup_b;
  logic       err_a, err_b;
  logic       par_wake, own_take;
  logic       own_rdy, fwd_rdy;
  fsync_id_t  own_rdy_id, fwd_rdy_id;
  fsync_lvl_t own_rdy_lvl, fwd_rdy_lvl;
  fsync_lvl_t dn_lvl_d;
  fsync_id_t  dn_id_d;

  assign bad_a = CHECK && ((ch_a_lvl_i == '0) || (ch_a_lvl_i > fsync_lvl_t'(N_LEVELS)));
  assign bad_b = CHECK && ((ch_b_lvl_i == '0) || (ch_b_lvl_i > fsync_lvl_t'(N_LEVELS)));

  // steer each request to the own file or the forward file by its target level.
  assign own_a = ch_a_valid_i && !bad_a && (ch_a_lvl_i == fsync_lvl_t'(LEVEL));
  assign own_b = ch_b_valid_i && !bad_b && (ch_b_lvl_i == fsync_lvl_t'(LEVEL));
  assign fwd_a = ch_a_valid_i && !bad_a && (ch_a_lvl_i > fsync_lvl_t'(LEVEL));
  assign fwd_b = ch_b_valid_i && !bad_b && (ch_b_lvl_i > fsync_lvl_t'(LEVEL));

  assign err_a = CHECK && ch_a_valid_i && (bad_a || own_dup_a || fwd_dup_a);
  assign err_b = CHECK && ch_b_valid_i && (bad_b || own_dup_b || fwd_dup_b);

  // a wake from above wins the dn port, then an error, then a local wake.
  assign par_wake = (par_msg_i == MSG_WAKE);
  assign own_take = own_rdy && !par_wake && !err_a && !err_b;

  fsync_node_rf i_own_rf (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .set_a_i     (own_a),
    .set_b_i     (own_b),
    .set_id_a_i  (ch_a_id_i),
    .set_id_b_i  (ch_b_id_i),
    .set_lvl_a_i (ch_a_lvl_i),
    .set_lvl_b_i (ch_b_lvl_i),
    .take_i      (own_take),
    .take_id_i   (own_rdy_id),
    .dup_a_o     (own_dup_a),
    .dup_b_o     (own_dup_b),
    .ready_o     (own_rdy),
    .ready_id_o  (own_rdy_id),
    .ready_lvl_o (own_rdy_lvl)
  );

  // the up port is never blocked, so a forward entry leaves as soon as it is ready.
  fsync_node_rf i_fwd_rf (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .set_a_i     (fwd_a),
    .set_b_i     (fwd_b),
    .set_id_a_i  (ch_a_id_i),
    .set_id_b_i  (ch_b_id_i),
    .set_lvl_a_i (ch_a_lvl_i),
    .set_lvl_b_i (ch_b_lvl_i),
    .take_i      (fwd_rdy),
    .take_id_i   (fwd_rdy_id),
    .dup_a_o     (fwd_dup_a),
    .dup_b_o     (fwd_dup_b),
    .ready_o     (fwd_rdy),
    .ready_id_o  (fwd_rdy_id),
    .ready_lvl_o (fwd_rdy_lvl)
  );

  always_comb begin
    if (par_wake) begin
      dn_lvl_d = par_lvl_i;
      dn_id_d  = par_id_i;
    end else if (err_a) begin
      dn_lvl_d = ch_a_lvl_i;
      dn_id_d  = ch_a_id_i;
    end else if (err_b) begin
      dn_lvl_d = ch_b_lvl_i;
      dn_id_d  = ch_b_id_i;
    end else begin
      dn_lvl_d = own_rdy_lvl;
      dn_id_d  = own_rdy_id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      up_valid_o <= 1'b0;
      ch_a_msg_o <= MSG_NONE;
      ch_b_msg_o <= MSG_NONE;
    end else begin
      up_valid_o <= fwd_rdy;
      if (par_wake || own_take) begin
        ch_a_msg_o <= MSG_WAKE;
        ch_b_msg_o <= MSG_WAKE;
      end else if (err_a) begin
        // errors go to one child only; child a is served first.
        ch_a_msg_o <= MSG_ERROR;
        ch_b_msg_o <= MSG_NONE;
      end else if (err_b) begin
        ch_a_msg_o <= MSG_NONE;
        ch_b_msg_o <= MSG_ERROR;
      end else begin
        ch_a_msg_o <= MSG_NONE;
        ch_b_msg_o <= MSG_NONE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    up_lvl_o <= fwd_rdy_lvl;
    up_id_o  <= fwd_rdy_id;
    dn_lvl_o <= dn_lvl_d;
    dn_id_o  <= dn_id_d;
  end

endmodule : fsync_node

//--- hw/fsync_nbr_node.sv
`timescale 1ns/1ps

module fsync_nbr_node (
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_a_i,
  input  logic req_b_i,
  output logic wake_a_o,
  output logic wake_b_o
);

  logic pend_a_q, pend_b_q;
  logic a_now, b_now, fire;

  // a repeated request from a side already waiting changes nothing.
  assign a_now = pend_a_q | req_a_i;
  assign b_now = pend_b_q | req_b_i;
  assign fire  = a_now & b_now;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_a_q <= 1'b0;
      pend_b_q <= 1'b0;
      wake_a_o <= 1'b0;
      wake_b_o <= 1'b0;
    end else begin
      pend_a_q <= a_now & ~fire;
      pend_b_q <= b_now & ~fire;
      // both sides are released in the same cycle.
      wake_a_o <= fire;
      wake_b_o <= fire;
    end
  end

endmodule : fsync_nbr_node

//--- hw/fsync_4x4.sv
`timescale 1ns/1ps

module fsync_4x4 (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_valid_i [fsync_pkg::N_CUS],
  input  fsync_pkg::fsync_lvl_t req_lvl_i [fsync_pkg::N_CUS],
  input  fsync_pkg::fsync_id_t  req_id_i [fsync_pkg::N_CUS],
  output logic                  wake_o [fsync_pkg::N_CUS],
  output fsync_pkg::fsync_lvl_t wake_lvl_o [fsync_pkg::N_CUS],
  output fsync_pkg::fsync_id_t  wake_id_o [fsync_pkg::N_CUS],
  output logic                  error_o [fsync_pkg::N_CUS],
  input  logic                  h_nbr_req_i [fsync_pkg::N_CUS],
  input  logic                  v_nbr_req_i [fsync_pkg::N_CUS],
  output logic                  h_nbr_wake_o [fsync_pkg::N_CUS],
  output logic                  v_nbr_wake_o [fsync_pkg::N_CUS]
);

  import fsync_pkg::*;

  localparam int unsigned N_L1 = N_CUS / 2;
  localparam int unsigned N_L2 = N_L1 / 2;
  localparam int unsigned N_L3 = N_L2 / 2;

  // upward links of levels 1 to 3; the root has nothing above it.
  logic       l1_up_v [N_L1];
  fsync_lvl_t l1_up_lvl [N_L1];
  fsync_id_t  l1_up_id [N_L1];
  logic       l2_up_v [N_L2];
  fsync_lvl_t l2_up_lvl [N_L2];
  fsync_id_t  l2_up_id [N_L2];
  logic       l3_up_v [N_L3];
  fsync_lvl_t l3_up_lvl [N_L3];
  fsync_id_t  l3_up_id [N_L3];

  // downward messages, per parent node and child side.
  fsync_msg_e l1_msg_a [N_L1];
  fsync_msg_e l1_msg_b [N_L1];
  fsync_lvl_t l1_dn_lvl [N_L1];
  fsync_id_t  l1_dn_id [N_L1];
  fsync_msg_e l2_msg_a [N_L2];
  fsync_msg_e l2_msg_b [N_L2];
  fsync_lvl_t l2_dn_lvl [N_L2];
  fsync_id_t  l2_dn_id [N_L2];
  fsync_msg_e l3_msg_a [N_L3];
  fsync_msg_e l3_msg_b [N_L3];
  fsync_lvl_t l3_dn_lvl [N_L3];
  fsync_id_t  l3_dn_id [N_L3];
  fsync_msg_e l4_msg_a, l4_msg_b;
  fsync_lvl_t l4_dn_lvl;
  fsync_id_t  l4_dn_id;

  // level 1 pairs columns 0-1 and 2-3 of one row.
  for (genvar i = 0; i < N_L1; i++) begin : gen_l1
    localparam int unsigned ROW = i / 2;
    localparam int unsigned CA = ROW * N_COLS + (i % 2) * 2;
    localparam int unsigned CB = CA + 1;
    localparam int unsigned PAR = (ROW / 2) * 2 + (i % 2);
    localparam bit SIDE_B = (ROW % 2) == 1;

    fsync_node #(.LEVEL(1)) i_node (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .ch_a_valid_i (req_valid_i[CA]),
      .ch_a_lvl_i   (req_lvl_i[CA]),
      .ch_a_id_i    (req_id_i[CA]),
      .ch_b_valid_i (req_valid_i[CB]),
      .ch_b_lvl_i   (req_lvl_i[CB]),
      .ch_b_id_i    (req_id_i[CB]),
      .par_msg_i    (SIDE_B ? l2_msg_b[PAR] : l2_msg_a[PAR]),
      .par_lvl_i    (l2_dn_lvl[PAR]),
      .par_id_i     (l2_dn_id[PAR]),
      .up_valid_o   (l1_up_v[i]),
      .up_lvl_o     (l1_up_lvl[i]),
      .up_id_o      (l1_up_id[i]),
      .ch_a_msg_o   (l1_msg_a[i]),
      .ch_b_msg_o   (l1_msg_b[i]),
      .dn_lvl_o     (l1_dn_lvl[i]),
      .dn_id_o      (l1_dn_id[i])
    );

    assign wake_o[CA]     = (l1_msg_a[i] == MSG_WAKE);
    assign wake_o[CB]     = (l1_msg_b[i] == MSG_WAKE);
    assign error_o[CA]    = (l1_msg_a[i] == MSG_ERROR);
    assign error_o[CB]    = (l1_msg_b[i] == MSG_ERROR);
    assign wake_lvl_o[CA] = l1_dn_lvl[i];
    assign wake_lvl_o[CB] = l1_dn_lvl[i];
    assign wake_id_o[CA]  = l1_dn_id[i];
    assign wake_id_o[CB]  = l1_dn_id[i];
  end

  // level 2 stacks two level-1 nodes vertically into a 2x2 block.
  for (genvar j = 0; j < N_L2; j++) begin : gen_l2
    localparam int unsigned RP = j / 2;
    localparam int unsigned CP = j % 2;
    localparam int unsigned KA = (2 * RP) * 2 + CP;
    localparam int unsigned KB = (2 * RP + 1) * 2 + CP;
    localparam bit SIDE_B = (CP == 1);

    fsync_node #(.LEVEL(2)) i_node (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .ch_a_valid_i (l1_up_v[KA]),
      .ch_a_lvl_i   (l1_up_lvl[KA]),
      .ch_a_id_i    (l1_up_id[KA]),
      .ch_b_valid_i (l1_up_v[KB]),
      .ch_b_lvl_i   (l1_up_lvl[KB]),
      .ch_b_id_i    (l1_up_id[KB]),
      .par_msg_i    (SIDE_B ? l3_msg_b[RP] : l3_msg_a[RP]),
      .par_lvl_i    (l3_dn_lvl[RP]),
      .par_id_i     (l3_dn_id[RP]),
      .up_valid_o   (l2_up_v[j]),
      .up_lvl_o     (l2_up_lvl[j]),
      .up_id_o      (l2_up_id[j]),
      .ch_a_msg_o   (l2_msg_a[j]),
      .ch_b_msg_o   (l2_msg_b[j]),
      .dn_lvl_o     (l2_dn_lvl[j]),
      .dn_id_o      (l2_dn_id[j])
    );
  end

  // level 3 joins the left and right blocks of one half.
  for (genvar k = 0; k < N_L3; k++) begin : gen_l3
    fsync_node #(.LEVEL(3)) i_node (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .ch_a_valid_i (l2_up_v[2*k]),
      .ch_a_lvl_i   (l2_up_lvl[2*k]),
      .ch_a_id_i    (l2_up_id[2*k]),
      .ch_b_valid_i (l2_up_v[2*k+1]),
      .ch_b_lvl_i   (l2_up_lvl[2*k+1]),
      .ch_b_id_i    (l2_up_id[2*k+1]),
      .par_msg_i    ((k == 1) ? l4_msg_b : l4_msg_a),
      .par_lvl_i    (l4_dn_lvl),
      .par_id_i     (l4_dn_id),
      .up_valid_o   (l3_up_v[k]),
      .up_lvl_o     (l3_up_lvl[k]),
      .up_id_o      (l3_up_id[k]),
      .ch_a_msg_o   (l3_msg_a[k]),
      .ch_b_msg_o   (l3_msg_b[k]),
      .dn_lvl_o     (l3_dn_lvl[k]),
      .dn_id_o      (l3_dn_id[k])
    );
  end

  // the root joins the top and bottom halves.
  fsync_node #(.LEVEL(4)) i_root (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ch_a_valid_i (l3_up_v[0]),
    .ch_a_lvl_i   (l3_up_lvl[0]),
    .ch_a_id_i    (l3_up_id[0]),
    .ch_b_valid_i (l3_up_v[1]),
    .ch_b_lvl_i   (l3_up_lvl[1]),
    .ch_b_id_i    (l3_up_id[1]),
    .par_msg_i    (MSG_NONE),
    .par_lvl_i    ('0),
    .par_id_i     ('0),
    .up_valid_o   (),
    .up_lvl_o     (),
    .up_id_o      (),
    .ch_a_msg_o   (l4_msg_a),
    .ch_b_msg_o   (l4_msg_b),
    .dn_lvl_o     (l4_dn_lvl),
    .dn_id_o      (l4_dn_id)
  );

  // horizontal neighbors pair columns 1 and 2; the edge columns stay idle.
  for (genvar r = 0; r < N_ROWS; r++) begin : gen_h_nbr
    localparam int unsigned A = r * N_COLS + 1;

    fsync_nbr_node i_nbr (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_a_i  (h_nbr_req_i[A]),
      .req_b_i  (h_nbr_req_i[A+1]),
      .wake_a_o (h_nbr_wake_o[A]),
      .wake_b_o (h_nbr_wake_o[A+1])
    );

    assign h_nbr_wake_o[r*N_COLS]          = 1'b0;
    assign h_nbr_wake_o[r*N_COLS+N_COLS-1] = 1'b0;
  end

  // vertical neighbors pair rows 1 and 2.
  for (genvar c = 0; c < N_COLS; c++) begin : gen_v_nbr
    localparam int unsigned A = N_COLS + c;

    fsync_nbr_node i_nbr (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_a_i  (v_nbr_req_i[A]),
      .req_b_i  (v_nbr_req_i[A+N_COLS]),
      .wake_a_o (v_nbr_wake_o[A]),
      .wake_b_o (v_nbr_wake_o[A+N_COLS])
    );

    assign v_nbr_wake_o[c]                   = 1'b0;
    assign v_nbr_wake_o[(N_ROWS-1)*N_COLS+c] = 1'b0;
  end

endmodule : fsync_4x4

//--- testbench/fsync_node_props.sv
`timescale 1ns/1ps

module fsync_node_props #(
  parameter int unsigned LEVEL = 1
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  up_valid_i,
  input fsync_pkg::fsync_lvl_t up_lvl_i,
  input fsync_pkg::fsync_msg_e ch_a_msg_i,
  input fsync_pkg::fsync_msg_e ch_b_msg_i
);

  import fsync_pkg::*;

  // the cycle after a reset edge every strobe of the node is low.
  quiet_after_reset: assert property (@(posedge clk_i)
    $past(reset_i) |-> (!up_valid_i && ch_a_msg_i == MSG_NONE && ch_b_msg_i == MSG_NONE))
    else $error("node outputs active right after reset");

  // only barriers aimed above this node are forwarded.
  up_level_above: assert property (@(posedge clk_i) disable iff (reset_i)
    up_valid_i |-> (up_lvl_i > fsync_lvl_t'(LEVEL)))
    else $error("forwarded level not above the node level");

  single_error_child: assert property (@(posedge clk_i) disable iff (reset_i)
    !(ch_a_msg_i == MSG_ERROR && ch_b_msg_i == MSG_ERROR))
    else $error("error sent to both children at once");

endmodule : fsync_node_props

bind fsync_node fsync_node_props #(.LEVEL(LEVEL)) i_props (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .up_valid_i (up_valid_o),
  .up_lvl_i   (up_lvl_o),
  .ch_a_msg_i (ch_a_msg_o),
  .ch_b_msg_i (ch_b_msg_o)
);

//--- testbench/tb_fsync_4x4.sv
`timescale 1ns/1ps

module tb_fsync_4x4;

  import fsync_pkg::*;

  localparam string DATA_FILE = "testbench/fsync_testdata.txt";
  localparam int DRAIN_LIMIT = 400;

  logic       clk;
  logic       reset;
  logic       req_valid [N_CUS];
  fsync_lvl_t req_lvl [N_CUS];
  fsync_id_t  req_id [N_CUS];
  logic       wake [N_CUS];
  fsync_lvl_t wake_lvl [N_CUS];
  fsync_id_t  wake_id [N_CUS];
  logic       error [N_CUS];
  logic       h_nbr_req [N_CUS];
  logic       v_nbr_req [N_CUS];
  logic       h_nbr_wake [N_CUS];
  logic       v_nbr_wake [N_CUS];

  // expected tree events per CU, coded as kind, level and id.
  int               exp_q [N_CUS][$];
  int               h_exp [N_CUS];
  int               v_exp [N_CUS];
  int               h_got [N_CUS];
  int               v_got [N_CUS];
  bit               h_pend [N_CUS];
  bit               v_pend [N_CUS];
  logic [N_CUS-1:0] arrived [N_LEVELS+1][N_IDS][N_CUS/2];
  bit               running;
  int               value_errs;
  int               event_errs;
  int               run_errs;

  fsync_4x4 dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .req_valid_i  (req_valid),
    .req_lvl_i    (req_lvl),
    .req_id_i     (req_id),
    .wake_o       (wake),
    .wake_lvl_o   (wake_lvl),
    .wake_id_o    (wake_id),
    .error_o      (error),
    .h_nbr_req_i  (h_nbr_req),
    .v_nbr_req_i  (v_nbr_req),
    .h_nbr_wake_o (h_nbr_wake),
    .v_nbr_wake_o (v_nbr_wake)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int code_of(input int kind, input int lvl, input int id);
    return kind * 256 + lvl * 16 + id;
  endfunction

  // barrier groups: a pair, a 2x2 block, two rows, or the whole grid.
  function automatic int group_of(input int cu, input int lvl);
    int row;
    int col;
    row = cu / N_COLS;
    col = cu % N_COLS;
    case (lvl)
      1: group_of = row * 2 + col / 2;
      2: group_of = (row / 2) * 2 + col / 2;
      3: group_of = row / 2;
      default: group_of = 0;
    endcase
  endfunction

  function automatic logic [N_CUS-1:0] group_mask(input int lvl, input int g);
    logic [N_CUS-1:0] m;
    m = '0;
    for (int c = 0; c < N_CUS; c++) begin
      if (group_of(c, lvl) == g) begin
        m[c] = 1'b1;
      end
    end
    return m;
  endfunction

  function automatic bit all_settled();
    bit ok;
    ok = 1'b1;
    for (int c = 0; c < N_CUS; c++) begin
      if (exp_q[c].size() != 0 || h_got[c] != h_exp[c] || v_got[c] != v_exp[c]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic check_value(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic clear_strobes();
    for (int c = 0; c < N_CUS; c++) begin
      req_valid[c] <= 1'b0;
      h_nbr_req[c] <= 1'b0;
      v_nbr_req[c] <= 1'b0;
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    clear_strobes();
  endtask

  task automatic random_gap();
    repeat ($urandom % 2) idle_cycle();
  endtask

  task automatic tree_request(input int cu, input int lvl, input int id);
    int               g;
    logic [N_CUS-1:0] m;
    random_gap();
    @(posedge clk);
    clear_strobes();
    req_valid[cu] <= 1'b1;
    req_lvl[cu]   <= fsync_lvl_t'(lvl);
    req_id[cu]    <= fsync_id_t'(id);
    // bad levels and repeated ids are dropped by the DUT; the data file lists their errors.
    if (lvl >= 1 && lvl <= N_LEVELS) begin
      g = group_of(cu, lvl);
      if (!arrived[lvl][id][g][cu]) begin
        arrived[lvl][id][g][cu] = 1'b1;
        m = group_mask(lvl, g);
        if (arrived[lvl][id][g] == m) begin
          for (int c = 0; c < N_CUS; c++) begin
            if (m[c]) begin
              exp_q[c].push_back(code_of(1, lvl, id));
            end
          end
          arrived[lvl][id][g] = '0;
        end
      end
    end
  endtask

  task automatic nbr_request(input byte dir, input int cu);
    int row;
    int col;
    int mate;
    row = cu / N_COLS;
    col = cu % N_COLS;
    random_gap();
    @(posedge clk);
    clear_strobes();
    if (dir == "h") begin
      h_nbr_req[cu] <= 1'b1;
      mate = (col == 1) ? cu + 1 : (col == 2) ? cu - 1 : -1;
      if (mate >= 0 && h_pend[mate]) begin
        h_pend[mate] = 1'b0;
        h_exp[cu]++;
        h_exp[mate]++;
      end else if (mate >= 0) begin
        h_pend[cu] = 1'b1;
      end
    end else begin
      v_nbr_req[cu] <= 1'b1;
      mate = (row == 1) ? cu + N_COLS : (row == 2) ? cu - N_COLS : -1;
      if (mate >= 0 && v_pend[mate]) begin
        v_pend[mate] = 1'b0;
        v_exp[cu]++;
        v_exp[mate]++;
      end else if (mate >= 0) begin
        v_pend[cu] = 1'b1;
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (!all_settled() && waited < DRAIN_LIMIT) begin
      idle_cycle();
      waited++;
    end
    if (!all_settled()) begin
      $display("timeout: expected wakes or errors missing after %0d cycles", DRAIN_LIMIT);
      run_errs++;
    end
  endtask

  task automatic run_file();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    string line;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", DATA_FILE);
      run_errs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1) begin
          case (line.getc(0))
            "R": begin
              n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d", a, b, c);
              tree_request(a, b, c);
            end
            "N": begin
              n = $sscanf(line.substr(3, line.len() - 1), "%d", a);
              nbr_request(line.getc(2), a);
            end
            "G": begin
              n = $sscanf(line.substr(1, line.len() - 1), "%d", a);
              repeat (a) idle_cycle();
            end
            "E": begin
              n = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
              exp_q[a].push_back(code_of(2, 0, b));
            end
            "D": drain();
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // errors carry only the id, so their level is left out of the match.
  task automatic check_event(input int cu);
    int kind;
    int got;
    int exp;
    int idx;
    kind = error[cu] ? 2 : 1;
    got  = code_of(kind, (kind == 1) ? int'(wake_lvl[cu]) : 0, int'(wake_id[cu]));
    if (wake[cu] && error[cu]) begin
      $display("cu %0d raised a wake and an error in the same cycle", cu);
      event_errs++;
    end
    if (exp_q[cu].size() == 0) begin
      $display("cu %0d got an unexpected %s with id %0d", cu,
               (kind == 1) ? "wake" : "error", wake_id[cu]);
      event_errs++;
    end else begin
      idx = 0;
      for (int i = exp_q[cu].size() - 1; i >= 0; i--) begin
        if (exp_q[cu][i] == got) begin
          idx = i;
        end
      end
      exp = exp_q[cu][idx];
      exp_q[cu].delete(idx);
      check_value($sformatf("error_o[%0d]", cu), int'(error[cu]), int'((exp >> 8) == 2));
      if ((exp >> 8) == 1) begin
        check_value($sformatf("wake_lvl_o[%0d]", cu), int'(wake_lvl[cu]), (exp >> 4) & 15);
      end
      check_value($sformatf("wake_id_o[%0d]", cu), int'(wake_id[cu]), exp & 15);
    end
  endtask

  always @(negedge clk) begin
    if (running) begin
      for (int c = 0; c < N_CUS; c++) begin
        if (wake[c] || error[c]) begin
          check_event(c);
        end
        if (h_nbr_wake[c]) begin
          h_got[c]++;
          if (h_got[c] > h_exp[c]) begin
            $display("cu %0d got an unexpected horizontal neighbor wake", c);
            event_errs++;
          end
        end
        if (v_nbr_wake[c]) begin
          v_got[c]++;
          if (v_got[c] > v_exp[c]) begin
            $display("cu %0d got an unexpected vertical neighbor wake", c);
            event_errs++;
          end
        end
      end
    end
  end

  initial begin
    void'($urandom(52));
    running = 1'b0;
    reset   = 1'b1;
    for (int c = 0; c < N_CUS; c++) begin
      req_valid[c] = 1'b0;
      req_lvl[c]   = '0;
      req_id[c]    = '0;
      h_nbr_req[c] = 1'b0;
      v_nbr_req[c] = 1'b0;
    end
    for (int l = 0; l <= N_LEVELS; l++) begin
      for (int i = 0; i < N_IDS; i++) begin
        for (int g = 0; g < N_CUS / 2; g++) begin
          arrived[l][i][g] = '0;
        end
      end
    end
    repeat (3) @(posedge clk);
    reset   <= 1'b0;
    running = 1'b1;
    run_file();
    drain();
    repeat (10) idle_cycle();
    $display("errors: %0d value, %0d event, %0d run", value_errs, event_errs, run_errs);
    if (value_errs + event_errs + run_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_fsync_4x4

//--- testbench/fsync_testdata.txt
# R cu lvl id = tree request, N h|v cu = neighbor request, G n = idle cycles
# E cu id = expected error on that cu, D = wait until all expected events arrive
R 0 1 0
R 1 1 0
R 14 1 3
R 15 1 3
D
R 8 3 2
R 2 2 1
R 9 3 2
R 0 1 1
R 3 2 1
R 10 3 2
R 11 3 2
R 6 2 1
R 12 3 2
R 1 1 1
R 13 3 2
R 7 2 1
R 14 3 2
R 15 3 2
D
R 5 0 1
E 5 1
R 9 7 2
E 9 2
R 4 1 3
R 4 1 3
E 4 3
G 3
R 5 1 3
D
N h 1
N h 2
N v 6
N v 10
N h 0
N v 3
N h 5
N h 5
N h 6
G 4
D
R 0 4 0
R 5 4 0
R 10 4 0
R 15 4 0
R 1 4 0
R 4 4 0
R 11 4 0
R 14 4 0
R 2 4 0
R 7 4 0
R 8 4 0
R 13 4 0
R 3 4 0
R 6 4 0
R 9 4 0
R 12 4 0
D

//--- sources.f
hw/fsync_pkg.sv
hw/fsync_node_rf.sv
hw/fsync_node.sv
hw/fsync_nbr_node.sv
hw/fsync_4x4.sv
testbench/fsync_node_props.sv
testbench/tb_fsync_4x4.sv

//--- Makefile
# Verilator build and run of the fractal barrier network testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_fsync_4x4
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION PASSED" $(LOG); then \
	  echo "sim: pass"; \
	else \
	  echo "sim: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
